//--- source/cpu_ctl_pkg.sv
// CPU control package with state codes, ALU and mux select codes and status flag positions
package cpu_ctl_pkg;

    parameter int state_width = 12;

    // Opcode states carry the opcode in the low byte, control states sit above 8'hFF
    typedef enum logic [state_width-1:0] {
        ora_imm = 12'h009, and_imm = 12'h029, eor_imm = 12'h049, adc_imm = 12'h069,
        ldy_imm = 12'h0A0, ldx_imm = 12'h0A2, lda_imm = 12'h0A9, cmp_imm = 12'h0C9,
        sbc_imm = 12'h0E9,
        clc_imp = 12'h018, sec_imp = 12'h038, cli_imp = 12'h058, sei_imp = 12'h078,
        clv_imp = 12'h0B8, cld_imp = 12'h0D8, nop_imp = 12'h0EA, sed_imp = 12'h0F8,
        bpl_rel = 12'h010, bmi_rel = 12'h030, bvc_rel = 12'h050, bvs_rel = 12'h070,
        bcc_rel = 12'h090, bcs_rel = 12'h0B0, bne_rel = 12'h0D0, beq_rel = 12'h0F0,
        fetch1 = 12'h100,
        fetch2,
        immediate,
        implied,
        branch,
        branch_check,
        branch_taken,
        branch_page,
        done_branch,
        error
    } cpu_state;

    typedef enum logic [3:0] {alu_nop, alu_adc, alu_sbc, alu_and, alu_ora, alu_eor} aluop_t;

    // ALU operand mux codes
    typedef enum logic [2:0] {
        sel_acc = 3'd0,
        sel_x   = 3'd1,
        sel_y   = 3'd2,
        sel_dl  = 3'd4,
        sel_pcl = 3'd5
    } alu_sel_t;

    typedef enum logic [1:0] {pcl_inc_path = 2'd0, pcl_alu = 2'd1} pcl_sel_t;

    typedef enum logic [1:0] {fix_none, fix_inc, fix_dec} page_fix_t;   // PCH fix after branch

    parameter logic [2:0] flag_c = 3'd0;
    parameter logic [2:0] flag_z = 3'd1;
    parameter logic [2:0] flag_i = 3'd2;
    parameter logic [2:0] flag_d = 3'd3;
    parameter logic [2:0] flag_v = 3'd6;
    parameter logic [2:0] flag_n = 3'd7;

endpackage

//--- source/opcode_classifier.sv
// Opcode classifier sorting the byte on the memory bus into the first state of its mode
`timescale 1ns/10ps

module opcode_classifier
    import cpu_ctl_pkg::*;
(
    input  logic [7:0] mem_data,
    output cpu_state   decode_state
);

    always_comb
    begin
        case ({4'h0, mem_data})   // Widened to the state code
            lda_imm,
            ldx_imm,
            ldy_imm,
            adc_imm,
            sbc_imm,
            and_imm,
            ora_imm,
            eor_imm,
            cmp_imm:
                decode_state = immediate;
            clc_imp,
            sec_imp,
            cli_imp,
            sei_imp,
            cld_imp,
            sed_imp,
            clv_imp,
            nop_imp:
                decode_state = implied;
            bpl_rel, bmi_rel, bvc_rel, bvs_rel,
            bcc_rel, bcs_rel, bne_rel, beq_rel:
                decode_state = branch;
            default:
                decode_state = error;   // Unsupported opcode
        endcase
    end

endmodule

//--- source/branch_unit.sv
// Branch unit evaluating the branch condition and holding the page fix of a taken branch
`timescale 1ns/10ps

module branch_unit
    import cpu_ctl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  cpu_state   state,
    input  logic [7:0] ir_in,
    input  logic [7:0] p_in,
    input  logic       data_bus_sign,
    input  logic       alu_c,
    output logic       branch_taken,
    output page_fix_t  page_fix
);

    logic test_flag;

    // Opcode bits 7:6 pick the flag under test
    always_comb
    begin
        case (ir_in[7:6])
            2'b00:   test_flag = p_in[flag_n];
            2'b01:   test_flag = p_in[flag_v];
            2'b10:   test_flag = p_in[flag_c];
            default: test_flag = p_in[flag_z];
        endcase
    end

    assign branch_taken = (state == branch_check) && (test_flag == ir_in[5]);   // Bit 5 wanted

    // PCL + offset carry decides the high byte correction
    always_ff @(posedge clk)
    begin
        if (reset)
            page_fix <= fix_none;
        else if (branch_taken)
        begin
            if (!data_bus_sign && alu_c)
                page_fix <= fix_inc;    // Forward across a page
            else if (data_bus_sign && !alu_c)
                page_fix <= fix_dec;    // Backward across a page
            else
                page_fix <= fix_none;
        end
    end

endmodule

//--- source/sequencer.sv
// Instruction sequencer holding the state register and the next-state rules
`timescale 1ns/10ps

module sequencer
    import cpu_ctl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  cpu_state   decode_state,
    input  logic [7:0] ir_in,
    input  logic       branch_taken,
    input  page_fix_t  page_fix,
    output cpu_state   state
);

    cpu_state state_next;
    cpu_state ir_state;

    assign ir_state = cpu_state'({4'h0, ir_in});   // Opcode state named by IR

    always_comb
    begin
        case (state)
            fetch1:
                state_next = fetch2;
            fetch2,
            lda_imm, ldx_imm, ldy_imm, adc_imm, sbc_imm,
            and_imm, ora_imm, eor_imm, cmp_imm,
            clc_imp, sec_imp, cli_imp, sei_imp,
            cld_imp, sed_imp, clv_imp, nop_imp:
                state_next = decode_state;
            immediate,
            implied,
            done_branch,
            branch_page:
                state_next = ir_state;
            bpl_rel, bmi_rel, bvc_rel, bvs_rel,
            bcc_rel, bcs_rel, bne_rel, beq_rel:
                state_next = branch;
            branch:
                state_next = branch_check;
            branch_check:
                state_next = branch_taken ? cpu_ctl_pkg::branch_taken : done_branch;
            cpu_ctl_pkg::branch_taken:
            begin
                if (page_fix == fix_none)
                    state_next = decode_state;
                else
                    state_next = branch_page;   // One more cycle for the PCH fix
            end
            default:
                state_next = error;   // Sticky until reset
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= fetch1;
        else
            state <= state_next;
    end

endmodule

//--- source/control_gen.sv
// Control generator driving the per-state strobes, ALU selects and the new status vector
`timescale 1ns/10ps

module control_gen
    import cpu_ctl_pkg::*;
(
    input  cpu_state   state,
    input  logic [7:0] p_in,
    input  logic       alu_n,
    input  logic       alu_v,
    input  logic       alu_z,
    input  logic       alu_c,
    input  logic       branch_taken,
    input  page_fix_t  page_fix,
    output logic       ir_ld,
    output logic       pcl_inc,
    output logic       pcl_ld,
    output logic       pch_inc,
    output logic       pch_dec,
    output logic       pclm_en,
    output logic       dl_ld,
    output logic       dld_en,
    output logic       xferd_en,
    output logic       alum_en,
    output logic       a_ld,
    output logic       x_ld,
    output logic       y_ld,
    output logic       amux_sel,
    output logic       p_ld,
    output logic       c_ctl,
    output pcl_sel_t   pclmux_sel,
    output alu_sel_t   alu_a_sel,
    output alu_sel_t   alu_b_sel,
    output aluop_t     aluop,
    output logic [7:0] ctl_pvect
);

    always_comb
    begin
        ir_ld      = 1'b0;
        pcl_inc    = 1'b0;
        pcl_ld     = 1'b0;
        pch_inc    = 1'b0;
        pch_dec    = 1'b0;
        pclm_en    = 1'b1;   // PC addresses memory by default
        dl_ld      = 1'b0;
        dld_en     = 1'b0;
        xferd_en   = 1'b0;
        alum_en    = 1'b0;
        a_ld       = 1'b0;
        x_ld       = 1'b0;
        y_ld       = 1'b0;
        amux_sel   = 1'b0;
        p_ld       = 1'b0;
        c_ctl      = 1'b0;
        pclmux_sel = pcl_inc_path;
        alu_a_sel  = sel_acc;
        alu_b_sel  = sel_acc;
        aluop      = alu_nop;
        ctl_pvect  = p_in;

        case (state)
            fetch1, implied:
                ir_ld = 1'b1;
            fetch2, branch_page:
            begin
                pcl_inc = 1'b1;
                ir_ld   = 1'b1;
            end
            done_branch:
                pcl_inc = 1'b1;
            immediate, branch:
            begin
                pcl_inc  = 1'b1;   // Operand byte into DL
                xferd_en = 1'b1;
                dl_ld    = 1'b1;
            end
            branch_check:
            begin
                if (branch_taken)
                begin
                    pclm_en    = 1'b0;   // PCL = PCL + DL
                    dld_en     = 1'b1;
                    alum_en    = 1'b1;
                    alu_a_sel  = sel_pcl;
                    alu_b_sel  = sel_dl;
                    aluop      = alu_adc;
                    pclmux_sel = pcl_alu;
                    pcl_ld     = 1'b1;
                end
                else
                begin
                    pcl_inc = 1'b1;
                    ir_ld   = 1'b1;
                end
            end
            cpu_ctl_pkg::branch_taken:
            begin
                ir_ld = 1'b1;
                case (page_fix)
                    fix_inc: pch_inc = 1'b1;
                    fix_dec: pch_dec = 1'b1;
                    default: pcl_inc = 1'b1;
                endcase
            end
            lda_imm, ldx_imm, ldy_imm, adc_imm, sbc_imm,
            and_imm, ora_imm, eor_imm, cmp_imm:
            begin
                pcl_inc           = 1'b1;
                ir_ld             = 1'b1;
                dld_en            = 1'b1;   // DL holds the operand
                p_ld              = 1'b1;
                alu_b_sel         = sel_dl;
                ctl_pvect[flag_n] = alu_n;
                ctl_pvect[flag_z] = alu_z;
            end
            clc_imp, sec_imp, cli_imp, sei_imp, cld_imp, sed_imp, clv_imp, nop_imp:
            begin
                pcl_inc = 1'b1;
                ir_ld   = 1'b1;
                p_ld    = (state != nop_imp);
            end
            default:
                ;
        endcase

        // Per-opcode register, ALU and flag details
        case (state)
            lda_imm:
            begin
                a_ld      = 1'b1;
                alu_a_sel = sel_dl;
            end
            ldx_imm:
            begin
                x_ld      = 1'b1;
                alu_a_sel = sel_x;
            end
            ldy_imm:
            begin
                y_ld      = 1'b1;
                alu_a_sel = sel_y;
            end
            adc_imm, sbc_imm:
            begin
                aluop             = (state == adc_imm) ? alu_adc : alu_sbc;
                c_ctl             = p_in[flag_c];   // Carry in from P
                amux_sel          = 1'b1;
                a_ld              = 1'b1;
                ctl_pvect[flag_v] = alu_v;
                ctl_pvect[flag_c] = alu_c;
            end
            and_imm, ora_imm, eor_imm:
            begin
                aluop    = (state == and_imm) ? alu_and :
                           (state == ora_imm) ? alu_ora : alu_eor;
                amux_sel = 1'b1;
                a_ld     = 1'b1;
            end
            cmp_imm:
            begin
                aluop             = alu_sbc;   // A - M, result dropped
                c_ctl             = 1'b1;
                ctl_pvect[flag_c] = alu_c;
            end
            clc_imp: ctl_pvect[flag_c] = 1'b0;
            sec_imp: ctl_pvect[flag_c] = 1'b1;
            cli_imp: ctl_pvect[flag_i] = 1'b0;
            sei_imp: ctl_pvect[flag_i] = 1'b1;
            cld_imp: ctl_pvect[flag_d] = 1'b0;
            sed_imp: ctl_pvect[flag_d] = 1'b1;
            clv_imp: ctl_pvect[flag_v] = 1'b0;
            default:
                ;
        endcase
    end

endmodule

//--- source/cpu_control.sv
// CPU control top level joining classifier, branch unit, sequencer and control generator
`timescale 1ns/10ps

module cpu_control
    import cpu_ctl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] p_in,
    input  logic [7:0] ir_in,
    input  logic [7:0] mem_data,
    input  logic       alu_n,
    input  logic       alu_v,
    input  logic       alu_z,
    input  logic       alu_c,
    input  logic       data_bus_sign,   // Sign of the branch offset
    output logic       ir_ld,
    output logic       pcl_inc,
    output logic       pcl_ld,
    output logic       pch_inc,
    output logic       pch_dec,
    output logic       pclm_en,
    output logic       dl_ld,
    output logic       dld_en,
    output logic       xferd_en,
    output logic       alum_en,
    output logic       a_ld,
    output logic       x_ld,
    output logic       y_ld,
    output logic       amux_sel,
    output logic       p_ld,
    output logic       c_ctl,
    output pcl_sel_t   pclmux_sel,
    output alu_sel_t   alu_a_sel,
    output alu_sel_t   alu_b_sel,
    output aluop_t     aluop,
    output logic [7:0] ctl_pvect,
    output cpu_state   state_out
);

    cpu_state  decode_state;
    logic      branch_taken;
    page_fix_t page_fix;

    opcode_classifier i_opcode_classifier (
        .mem_data     (mem_data),
        .decode_state (decode_state)
    );

    branch_unit i_branch_unit (
        .clk           (clk),
        .reset         (reset),
        .state         (state_out),
        .ir_in         (ir_in),
        .p_in          (p_in),
        .data_bus_sign (data_bus_sign),
        .alu_c         (alu_c),
        .branch_taken  (branch_taken),
        .page_fix      (page_fix)
    );

    sequencer i_sequencer (
        .clk          (clk),
        .reset        (reset),
        .decode_state (decode_state),
        .ir_in        (ir_in),
        .branch_taken (branch_taken),
        .page_fix     (page_fix),
        .state        (state_out)
    );

    control_gen i_control_gen (
        .state        (state_out),
        .p_in         (p_in),
        .alu_n        (alu_n),
        .alu_v        (alu_v),
        .alu_z        (alu_z),
        .alu_c        (alu_c),
        .branch_taken (branch_taken),
        .page_fix     (page_fix),
        .ir_ld        (ir_ld),
        .pcl_inc      (pcl_inc),
        .pcl_ld       (pcl_ld),
        .pch_inc      (pch_inc),
        .pch_dec      (pch_dec),
        .pclm_en      (pclm_en),
        .dl_ld        (dl_ld),
        .dld_en       (dld_en),
        .xferd_en     (xferd_en),
        .alum_en      (alum_en),
        .a_ld         (a_ld),
        .x_ld         (x_ld),
        .y_ld         (y_ld),
        .amux_sel     (amux_sel),
        .p_ld         (p_ld),
        .c_ctl        (c_ctl),
        .pclmux_sel   (pclmux_sel),
        .alu_a_sel    (alu_a_sel),
        .alu_b_sel    (alu_b_sel),
        .aluop        (aluop),
        .ctl_pvect    (ctl_pvect)
    );

endmodule

//--- verification/cpu_control_chk.sv
// Sequencing checker with assertions on reset entry, page fix strobes and the error hold
`timescale 1ns/10ps

module cpu_control_chk
    import cpu_ctl_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input cpu_state state,
    input logic     pch_inc,
    input logic     pch_dec
);

    int fail_count = 0;

    reset_to_fetch1: assert property (@(posedge clk) reset |=> state == fetch1)
    else
    begin
        $error("state is not FETCH1 one cycle after reset");
        fail_count++;
    end

    pch_exclusive: assert property (@(posedge clk) !(pch_inc && pch_dec))
    else
    begin
        $error("pch_inc and pch_dec are high together");
        fail_count++;
    end

    error_sticky: assert property (@(posedge clk) (state == error && !reset) |=> state == error)
    else
    begin
        $error("ERROR state left without reset");
        fail_count++;
    end

endmodule

// PCH strobes live at the top level, so the checker hooks in there
bind cpu_control cpu_control_chk i_cpu_control_chk (
    .clk     (clk),
    .reset   (reset),
    .state   (state_out),
    .pch_inc (pch_inc),
    .pch_dec (pch_dec)
);

//--- verification/cpu_control_tb.sv
// Testbench for the CPU control block, standing in for datapath and memory around the DUT
`timescale 1ns/10ps

module cpu_control_tb
    import cpu_ctl_pkg::*;
();

    logic       clk;
    logic       reset;
    logic [7:0] p_in;
    logic [7:0] ir_in;
    logic [7:0] mem_data;
    logic       alu_n;
    logic       alu_v;
    logic       alu_z;
    logic       alu_c;
    logic       data_bus_sign;
    logic       ir_ld;
    logic       pcl_inc;
    logic       pcl_ld;
    logic       pch_inc;
    logic       pch_dec;
    logic       pclm_en;
    logic       dl_ld;
    logic       dld_en;
    logic       xferd_en;
    logic       alum_en;
    logic       a_ld;
    logic       x_ld;
    logic       y_ld;
    logic       amux_sel;
    logic       p_ld;
    logic       c_ctl;
    pcl_sel_t   pclmux_sel;
    alu_sel_t   alu_a_sel;
    alu_sel_t   alu_b_sel;
    aluop_t     aluop;
    logic [7:0] ctl_pvect;
    cpu_state   state_out;

    int errors;
    int checks;
    int seed;

    cpu_control i_cpu_control (.*);

    always #5 clk = ~clk;   // 10 ns period

    task automatic tick();
        @(posedge clk);
        #1;   // Inputs change just after the edge
    endtask

    task automatic settle();
        #2;
    endtask

    task automatic check_state(input cpu_state actual, input cpu_state expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s state %s, expected %s", $time, what,
                     actual.name(), expected.name());
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_aluop(input aluop_t actual, input aluop_t expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s is %s, expected %s", $time, what,
                     actual.name(), expected.name());
        end
    endtask

    task automatic check_alu_sel(input alu_sel_t actual, input alu_sel_t expected,
                                 input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s is %s, expected %s", $time, what,
                     actual.name(), expected.name());
        end
    endtask

    task automatic check_pcl_sel(input pcl_sel_t actual, input pcl_sel_t expected,
                                 input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %0t: %s is %s, expected %s", $time, what,
                     actual.name(), expected.name());
        end
    endtask

    // Step cycles until state_out matches, giving up after max_cycles
    task automatic wait_state(input cpu_state target, input int max_cycles);
        int count;
        count = 0;
        do
        begin
            tick();
            count++;
        end
        while (state_out != target && count < max_cycles);
        if (state_out != target)
        begin
            errors++;
            $display("Timeout: state_out did not reach %s within %0d cycles",
                     target.name(), max_cycles);
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("Test %s finished with %0d errors", name, errors - start);
    endtask

    function automatic aluop_t imm_aluop(input logic [7:0] op);
        case (op)
            8'h69:        return alu_adc;
            8'hE9, 8'hC9: return alu_sbc;   // CMP subtracts as well
            8'h29:        return alu_and;
            8'h09:        return alu_ora;
            8'h49:        return alu_eor;
            default:      return alu_nop;   // Loads pass DL through
        endcase
    endfunction

    // Status vector expected after an immediate opcode
    function automatic logic [7:0] imm_expected(input logic [7:0] op, input logic [7:0] p,
                                               input logic n, input logic v,
                                               input logic z, input logic c);
        logic [7:0] pv;
        pv    = p;
        pv[7] = n;
        pv[1] = z;
        if (op == 8'h69 || op == 8'hE9)
        begin
            pv[6] = v;
            pv[0] = c;
        end
        else if (op == 8'hC9)
            pv[0] = c;
        return pv;
    endfunction

    function automatic logic [7:0] flag_expected(input logic [7:0] op, input logic [7:0] p);
        logic [7:0] pv;
        pv = p;
        case (op)
            8'h18:   pv[0] = 1'b0;   // CLC
            8'h38:   pv[0] = 1'b1;   // SEC
            8'h58:   pv[2] = 1'b0;   // CLI
            8'h78:   pv[2] = 1'b1;   // SEI
            8'hD8:   pv[3] = 1'b0;   // CLD
            8'hF8:   pv[3] = 1'b1;   // SED
            8'hB8:   pv[6] = 1'b0;   // CLV
            default: ;               // NOP
        endcase
        return pv;
    endfunction

    function automatic logic branch_expected(input logic [7:0] op, input logic [7:0] p);
        case (op)
            8'h10:   return !p[7];   // BPL
            8'h30:   return p[7];    // BMI
            8'h50:   return !p[6];   // BVC
            8'h70:   return p[6];    // BVS
            8'h90:   return !p[0];   // BCC
            8'hB0:   return p[0];    // BCS
            8'hD0:   return !p[1];   // BNE
            default: return p[1];    // BEQ
        endcase
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) tick();
        reset = 1'b0;
        settle();
        check_state(state_out, fetch1, "after reset");
    endtask

    task automatic reset_test();
        int start;
        start = errors;
        apply_reset();
        check_bit(ir_ld, 1'b1, "fetch1 ir_ld");
        check_byte({a_ld, x_ld, y_ld, p_ld, pcl_ld, pch_inc, pch_dec, pcl_inc}, 8'h00,
                   "fetch1 load strobes");
        tick();
        settle();
        check_state(state_out, fetch2, "second fetch");
        check_bit(pcl_inc, 1'b1, "fetch2 pcl_inc");
        check_bit(ir_ld, 1'b1, "fetch2 ir_ld");
        report_test("reset", start);
    endtask

    task automatic immediate_test();
        logic [7:0] ops [9];
        logic [7:0] op;
        logic [7:0] p;
        logic       n;
        logic       v;
        logic       z;
        logic       c;
        string      tag;
        int         start;
        ops   = '{8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9};
        start = errors;
        foreach (ops[i])
        begin
            op  = ops[i];
            tag = $sformatf("op %h", op);
            wait_state(nop_imp, 4);
            mem_data = op;
            ir_in    = op;
            tick();
            settle();
            check_state(state_out, immediate, {tag, " mode"});
            check_bit(dl_ld, 1'b1, {tag, " dl_ld"});
            check_bit(xferd_en, 1'b1, {tag, " xferd_en"});
            check_bit(pcl_inc, 1'b1, {tag, " operand pcl_inc"});
            tick();
            p        = 8'($random(seed));
            n        = 1'($random(seed));
            v        = 1'($random(seed));
            z        = 1'($random(seed));
            c        = 1'($random(seed));
            p_in     = p;
            alu_n    = n;
            alu_v    = v;
            alu_z    = z;
            alu_c    = c;
            mem_data = 8'hEA;   // Park on NOP afterwards
            ir_in    = 8'hEA;
            settle();
            check_state(state_out, cpu_state'({4'h0, op}), {tag, " execute"});
            check_bit(a_ld, op inside {8'hA9, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49}, {tag, " a_ld"});
            check_bit(x_ld, op == 8'hA2, {tag, " x_ld"});
            check_bit(y_ld, op == 8'hA0, {tag, " y_ld"});
            check_bit(amux_sel, op inside {8'h69, 8'hE9, 8'h29, 8'h09, 8'h49},
                      {tag, " amux_sel"});
            check_bit(dld_en, 1'b1, {tag, " dld_en"});
            check_aluop(aluop, imm_aluop(op), {tag, " aluop"});
            check_bit(c_ctl, (op == 8'h69 || op == 8'hE9) ? p[0] : (op == 8'hC9), {tag, " c_ctl"});
            check_byte(ctl_pvect, imm_expected(op, p, n, v, z, c), {tag, " ctl_pvect"});
        end
        report_test("immediate", start);
    endtask

    task automatic flag_test();
        logic [7:0] ops [8];
        logic [7:0] op;
        logic [7:0] p;
        string      tag;
        int         start;
        ops   = '{8'h18, 8'h38, 8'h58, 8'h78, 8'hD8, 8'hF8, 8'hB8, 8'hEA};
        start = errors;
        foreach (ops[i])
        begin
            op  = ops[i];
            tag = $sformatf("op %h", op);
            wait_state(nop_imp, 4);
            mem_data = op;
            ir_in    = op;
            tick();
            settle();
            check_state(state_out, implied, {tag, " mode"});
            tick();
            p        = 8'($random(seed));
            p_in     = p;
            mem_data = 8'hEA;
            ir_in    = 8'hEA;
            settle();
            check_state(state_out, cpu_state'({4'h0, op}), {tag, " execute"});
            check_byte(ctl_pvect, flag_expected(op, p), {tag, " ctl_pvect"});
            check_bit(p_ld, op != 8'hEA, {tag, " p_ld"});
        end
        report_test("flag", start);
    endtask

    task automatic branch_test();
        logic [7:0] ops [8];
        logic [7:0] op;
        logic [7:0] p;
        logic       taken;
        string      tag;
        int         start;
        ops   = '{8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0};
        start = errors;
        foreach (ops[i])
        begin
            op    = ops[i];
            p     = 8'($random(seed));
            taken = branch_expected(op, p);
            tag   = $sformatf("op %h p %h", op, p);
            wait_state(nop_imp, 4);
            mem_data      = op;
            ir_in         = op;
            p_in          = p;
            data_bus_sign = 1'b0;   // No page crossing
            alu_c         = 1'b0;
            tick();
            settle();
            check_state(state_out, branch, {tag, " entry"});
            tick();
            settle();
            check_state(state_out, branch_check, {tag, " check"});
            check_bit(pcl_ld, taken, {tag, " pcl_ld"});
            check_bit(pcl_inc, !taken, {tag, " pcl_inc"});
            check_bit(pclm_en, !taken, {tag, " pclm_en"});
            check_bit(dld_en, taken, {tag, " dld_en"});
            check_bit(alum_en, taken, {tag, " alum_en"});
            check_pcl_sel(pclmux_sel, taken ? pcl_alu : pcl_inc_path, {tag, " pclmux_sel"});
            check_alu_sel(alu_a_sel, taken ? sel_pcl : sel_acc, {tag, " alu_a_sel"});
            check_alu_sel(alu_b_sel, taken ? sel_dl : sel_acc, {tag, " alu_b_sel"});
            check_aluop(aluop, taken ? alu_adc : alu_nop, {tag, " offset aluop"});
            tick();
            mem_data = 8'hEA;
            ir_in    = 8'hEA;
            settle();
            check_state(state_out, taken ? branch_taken : done_branch, {tag, " third"});
            tick();
            settle();
            check_state(state_out, taken ? implied : nop_imp, {tag, " fourth"});
        end
        report_test("branch", start);
    endtask

    task automatic page_fix_test();
        logic sign [3];
        logic carry [3];
        logic inc;
        logic dec;
        int   start;
        sign  = '{1'b0, 1'b1, 1'b0};
        carry = '{1'b1, 1'b0, 1'b0};
        start = errors;
        foreach (sign[i])
        begin
            inc = !sign[i] && carry[i];   // Forward into next page
            dec = sign[i] && !carry[i];   // Back into previous page
            wait_state(nop_imp, 4);
            mem_data = 8'hF0;   // BEQ with Z set
            ir_in    = 8'hF0;
            p_in     = 8'h02;
            tick();
            settle();
            check_state(state_out, branch, "page fix entry");
            tick();
            data_bus_sign = sign[i];
            alu_c         = carry[i];
            settle();
            check_state(state_out, branch_check, "page fix check");
            tick();
            mem_data = 8'hEA;
            ir_in    = 8'hEA;
            settle();
            check_state(state_out, branch_taken, "page fix taken");
            check_bit(pch_inc, inc, "page fix pch_inc");
            check_bit(pch_dec, dec, "page fix pch_dec");
            check_bit(pcl_inc, !(inc || dec), "page fix pcl_inc");
            tick();
            settle();
            if (inc || dec)
            begin
                check_state(state_out, branch_page, "page fix extra cycle");
                tick();
                settle();
                check_state(state_out, nop_imp, "page fix return");
            end
            else
                check_state(state_out, implied, "page fix skipped");
        end
        report_test("page_fix", start);
    endtask

    task automatic error_test();
        int start;
        start = errors;
        wait_state(nop_imp, 4);
        mem_data = 8'hFF;   // Not a supported opcode
        tick();
        settle();
        check_state(state_out, error, "unsupported opcode");
        repeat (16)
        begin
            tick();
            mem_data = 8'($random(seed));
            settle();
            check_state(state_out, error, "error hold");
        end
        tick();
        apply_reset();
        report_test("error", start);
    endtask

    initial
    begin
        seed          = 11;
        errors        = 0;
        checks        = 0;
        clk           = 1'b0;
        reset         = 1'b1;
        p_in          = 8'h00;
        ir_in         = 8'hEA;
        mem_data      = 8'hEA;
        alu_n         = 1'b0;
        alu_v         = 1'b0;
        alu_z         = 1'b0;
        alu_c         = 1'b0;
        data_bus_sign = 1'b0;
        reset_test();
        immediate_test();
        flag_test();
        branch_test();
        page_fix_test();
        error_test();
        errors += i_cpu_control.i_cpu_control_chk.fail_count;   // Bound assertion failures
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- flist.f
source/cpu_ctl_pkg.sv
source/opcode_classifier.sv
source/branch_unit.sv
source/sequencer.sv
source/control_gen.sv
source/cpu_control.sv
verification/cpu_control_chk.sv
verification/cpu_control_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_control_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
